// ==== list.f ====
hw/msx_bus_pkg.sv
hw/sdc_pkg.sv
hw/cart_bus_if.sv
hw/mux_bus_sampler.sv
hw/sdc_registers.sv
hw/megaram_config.sv
hw/msx_cart_top.sv
verification/tb_msx_cart.sv

// ==== run.sh ====
#!/bin/sh
# build the simulation from list.f and run it, a failing run returns a nonzero status
verilator --binary --top-module tb_msx_cart -f list.f && ./obj_dir/Vtb_msx_cart || exit 1

// ==== verification/tb_msx_cart.sv ====
module tb_msx_cart;
    timeunit 1ns;
    timeprecision 100ps;
    import msx_bus_pkg::*;
    import sdc_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int SETUP_CYCLES = 7;    // one sampler period
    localparam int HOLD_CYCLES  = 21;   // three sampler periods
    localparam int ENTRY_CYCLES = 40;   // watchdog budget per table entry

    typedef enum logic [1:0] {IO_WR, MEM_WR, MEM_RD} op_t;

    typedef struct packed {
        op_t     kind;
        addr_t   addr;
        data_t   data;
        data_t   exp_byte;      // read data while datadir is low
        logic    exp_seen;      // datadir expected low during the read
        mapper_t exp_map;
        logic    exp_scc;
        logic    exp_req;       // sd request open after this entry
        logic    done_after;    // engine finishes after this entry
    } entry_t;

    logic       clk108_w         = 1'b0;
    logic       ram_enabled_w    = 1'b0;
    data_t      mp               = 8'hFF;
    logic       rd_n             = 1'b1;
    logic       wr_n             = 1'b1;
    logic       sltsl_n          = 1'b1;
    logic       sd_req_ready     = 1'b0;
    logic       sd_done          = 1'b0;
    card_type_t sd_card_type     = '0;
    logic       sd_crc_error     = 1'b0;
    logic       sd_timeout_error = 1'b0;

    msel_t   msel_n;
    logic    datadir;
    logic    sd_req_valid;
    logic    sd_req_write;
    sector_t sd_sector;
    mapper_t mapper_type;
    logic    scc_enable;

    wire [DATA_W-1:0] cd;
    data_t cd_drv   = '0;
    logic  cd_oe    = 1'b0;
    addr_t cur_addr = '0;       // bus cycle seen by the mp mux model
    data_t cur_ctrl = 8'hFF;

    entry_t  tbl[$];
    sector_t sector_exp;
    logic    table_built = 1'b0;
    int      errors = 0;

    msx_cart_top msx_cart_top_i (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .mp               (mp),
        .rd_n             (rd_n),
        .wr_n             (wr_n),
        .sltsl_n          (sltsl_n),
        .sd_req_ready     (sd_req_ready),
        .sd_done          (sd_done),
        .sd_card_type     (sd_card_type),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .msel_n           (msel_n),
        .datadir          (datadir),
        .sd_req_valid     (sd_req_valid),
        .sd_req_write     (sd_req_write),
        .sd_sector        (sd_sector),
        .mapper_type      (mapper_type),
        .scc_enable       (scc_enable),
        .cd               (cd)
    );

    assign cd = cd_oe ? cd_drv : 'z;

    always #(CLK_NS / 2) clk108_w = ~clk108_w;

    // external bus mux following the group selected in the last cycle
    always @(posedge clk108_w) begin
        case (msel_n)
            MSEL_ADDR_LO: mp <= cur_addr[7:0];
            MSEL_ADDR_HI: mp <= cur_addr[15:8];
            MSEL_CTRL:    mp <= cur_ctrl;
            default:      mp <= 8'hFF;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_byte(input string what, input data_t got, input data_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %02h, expected %02h", what, got, exp));
    endtask

    task automatic check_msel(input msel_t got, input msel_t exp);
        if (got !== exp)
            report_mismatch($sformatf("msel_n is %b, expected %b", got, exp));
    endtask

    task automatic check_mapper(input mapper_t got, input mapper_t exp);
        if (got !== exp)
            report_mismatch($sformatf("mapper_type is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_sector(input sector_t got, input sector_t exp);
        if (got !== exp)
            report_mismatch($sformatf("sd_sector is %08h, expected %08h", got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // control group with merq_n or iorq_n pulled low and m1_n high
    function automatic data_t ctrl_byte(input op_t kind);
        data_t b;
        b = 8'hFF;
        if (kind == IO_WR) b[MP_IORQ] = 1'b0;
        else b[MP_MERQ] = 1'b0;
        return b;
    endfunction

    function automatic msel_t expected_msel(input int step);
        case (step)
            0, 1:    return MSEL_ADDR_LO;
            2, 3:    return MSEL_ADDR_HI;
            4, 5:    return MSEL_CTRL;
            default: return MSEL_NONE;
        endcase
    endfunction

    task automatic add_io(input data_t code, input mapper_t exp_map, input logic exp_scc);
        entry_t e;
        e = '0;
        e.kind    = IO_WR;
        e.addr    = {8'h00, MAPPER_CFG_PORT};
        e.data    = code;
        e.exp_map = exp_map;
        e.exp_scc = exp_scc;
        tbl.push_back(e);
    endtask

    task automatic add_mem(input op_t kind, input addr_t addr, input data_t data,
                           input logic exp_seen, input logic exp_req, input logic done_after);
        entry_t e;
        e = '0;
        e.kind       = kind;
        e.addr       = addr;
        e.data       = data;         // byte driven on writes
        e.exp_byte   = data;
        e.exp_seen   = exp_seen;
        e.exp_req    = exp_req;
        e.done_after = done_after;
        tbl.push_back(e);
    endtask

    // address first with the bus idle and then the strobe for three periods
    task automatic run_cycle(input entry_t e, output logic seen, output data_t got);
        seen = 1'b0;
        got  = 8'h00;
        @(posedge clk108_w);
        cur_addr <= e.addr;
        cur_ctrl <= 8'hFF;
        repeat (SETUP_CYCLES) @(posedge clk108_w);
        cur_ctrl <= ctrl_byte(e.kind);
        sltsl_n  <= (e.kind == IO_WR);
        if (e.kind == MEM_RD) begin
            rd_n <= 1'b0;
        end else begin
            wr_n   <= 1'b0;
            cd_drv <= e.data;
            cd_oe  <= 1'b1;
        end
        repeat (HOLD_CYCLES) begin
            @(negedge clk108_w);
            if (datadir === 1'b0) begin
                seen = 1'b1;
                got  = cd;
            end
        end
        @(posedge clk108_w);
        rd_n     <= 1'b1;
        wr_n     <= 1'b1;
        sltsl_n  <= 1'b1;
        cd_oe    <= 1'b0;
        cur_ctrl <= 8'hFF;
        repeat (3) @(posedge clk108_w);     // strobe sync plus datadir release
        @(negedge clk108_w);
    endtask

    task automatic serve_request(input sector_t exp_sector);
        check_sector(sd_sector, exp_sector);
        check_bit("sd_req_write", sd_req_write, 1'b0);
        repeat (4) begin
            @(negedge clk108_w);
            check_bit("sd_req_valid before ready", sd_req_valid, 1'b1);
            check_sector(sd_sector, exp_sector);
        end
        @(posedge clk108_w);
        sd_req_ready <= 1'b1;
        @(posedge clk108_w);
        sd_req_ready <= 1'b0;
        @(negedge clk108_w);
        check_bit("sd_req_valid after ready", sd_req_valid, 1'b0);
    endtask

    task automatic pulse_done();
        @(posedge clk108_w);
        sd_done <= 1'b1;
        @(posedge clk108_w);
        sd_done <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic       seen;
        data_t      got;
        logic [31:0] rnd;
        data_t      other;
        card_type_t ctype;
        data_t      busy_status;
        entry_t     e;
        int         step;

        rnd = $urandom(45);     // seed once
        rnd = $urandom;
        ctype = rnd[1:0];
        sd_card_type <= ctype;
        sector_exp = $urandom;
        do begin
            rnd   = $urandom;
            other = rnd[7:0];
        end while (other == CFG_KONAMI_SCC || other == CFG_ASCII16 || other == CFG_ASCII8);
        busy_status = '0;
        busy_status[STAT_BUSY_BIT] = 1'b1;

        add_io(CFG_KONAMI_SCC, MAP_KONAMI_SCC, 1'b1);
        add_io(CFG_ASCII16, MAP_ASCII16, 1'b0);
        add_io(CFG_ASCII8, MAP_ASCII8, 1'b0);
        add_io(other, MAP_KONAMI, 1'b0);
        add_mem(MEM_RD, SDC_STATUS, 8'h00, 1'b0, 1'b0, 1'b0);      // window closed
        add_mem(MEM_WR, SDC_ENABLE, 8'h01, 1'b0, 1'b0, 1'b0);
        add_mem(MEM_RD, SDC_ENABLE, 8'h01, 1'b1, 1'b0, 1'b0);
        add_mem(MEM_WR, SDC_SADDR, sector_exp[7:0], 1'b0, 1'b0, 1'b0);
        add_mem(MEM_WR, SDC_SADDR + 16'd1, sector_exp[15:8], 1'b0, 1'b0, 1'b0);
        add_mem(MEM_WR, SDC_SADDR + 16'd2, sector_exp[23:16], 1'b0, 1'b0, 1'b0);
        add_mem(MEM_WR, SDC_SADDR + 16'd3, sector_exp[31:24], 1'b0, 1'b0, 1'b0);
        add_mem(MEM_RD, SDC_SADDR + 16'd2, sector_exp[23:16], 1'b1, 1'b0, 1'b0);
        add_mem(MEM_WR, SDC_CMD, 8'h01, 1'b0, 1'b1, 1'b0);         // sector read
        add_mem(MEM_RD, SDC_STATUS, busy_status, 1'b1, 1'b0, 1'b1);
        add_mem(MEM_RD, SDC_STATUS, 8'h00, 1'b1, 1'b0, 1'b0);
        add_mem(MEM_RD, SDC_CTYPE, {6'b0, ctype}, 1'b1, 1'b0, 1'b0);
        add_mem(MEM_RD, 16'h7E40, 8'hFF, 1'b1, 1'b0, 1'b0);        // unused byte
        table_built = 1'b1;

        repeat (4) @(posedge clk108_w);
        @(negedge clk108_w);
        check_msel(msel_n, MSEL_NONE);
        check_bit("datadir in reset", datadir, 1'b1);
        check_bit("sd_req_valid in reset", sd_req_valid, 1'b0);
        @(posedge clk108_w);
        ram_enabled_w <= 1'b1;
        @(negedge clk108_w);
        check_mapper(mapper_type, MAP_KONAMI_SCC);
        check_bit("scc_enable after reset", scc_enable, 1'b1);

        // sequencer leaves idle on the first edge out of reset
        step = 0;
        while (msel_n != MSEL_ADDR_LO && step < 8) begin
            @(negedge clk108_w);
            step++;
        end
        if (msel_n != MSEL_ADDR_LO) begin
            $display("msel_n never selected the low address group after reset");
            stop_run();
        end
        for (int i = 0; i < 14; i++) begin
            check_msel(msel_n, expected_msel(i % 7));
            @(negedge clk108_w);
        end

        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            run_cycle(e, seen, got);
            if (e.kind == IO_WR) begin
                check_mapper(mapper_type, e.exp_map);
                check_bit("scc_enable", scc_enable, e.exp_scc);
            end else if (e.kind == MEM_RD) begin
                check_bit("datadir low during read", seen, e.exp_seen);
                if (e.exp_seen) check_byte("read data", got, e.exp_byte);
            end
            check_bit("sd_req_valid", sd_req_valid, e.exp_req);
            if (e.exp_req) serve_request(sector_exp);
            if (e.done_after) pulse_done();
        end

        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run();
        end
    end

    // watchdog sized from the table
    initial begin
        int limit_ns;
        wait (table_built);
        limit_ns = tbl.size() * ENTRY_CYCLES * CLK_NS;
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        stop_run();
    end

endmodule

// ==== hw/msx_cart_top.sv ====
module msx_cart_top (
    input  logic                 clk108_w,
    input  logic                 ram_enabled_w,
    input  msx_bus_pkg::data_t   mp,
    input  logic                 rd_n,
    input  logic                 wr_n,
    input  logic                 sltsl_n,
    input  logic                 sd_req_ready,
    input  logic                 sd_done,
    input  sdc_pkg::card_type_t  sd_card_type,
    input  logic                 sd_crc_error,
    input  logic                 sd_timeout_error,
    output msx_bus_pkg::msel_t   msel_n,
    output logic                 datadir,
    output logic                 sd_req_valid,
    output logic                 sd_req_write,
    output sdc_pkg::sector_t     sd_sector,
    output sdc_pkg::mapper_t     mapper_type,
    output logic                 scc_enable,
    inout  msx_bus_pkg::data_t   cd
);
    import msx_bus_pkg::*;

    data_t rd_data;

    cart_bus_if bus_if ();

    mux_bus_sampler mux_bus_sampler_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .cd_in         (cd),
        .msel_n        (msel_n),
        .bus           (bus_if.sampler)
    );

    sdc_registers sdc_registers_i (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .bus              (bus_if.decoder),
        .sd_req_valid     (sd_req_valid),
        .sd_req_write     (sd_req_write),
        .sd_sector        (sd_sector),
        .sd_req_ready     (sd_req_ready),
        .sd_done          (sd_done),
        .sd_card_type     (sd_card_type),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .rd_data          (rd_data),
        .datadir          (datadir)
    );

    megaram_config megaram_config_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus_if.decoder),
        .mapper_type   (mapper_type),
        .scc_enable    (scc_enable)
    );

    // drive cd only while the level shifter points at the msx
    assign cd = datadir ? 'z : rd_data;

endmodule

// ==== hw/megaram_config.sv ====
module megaram_config (
    input  logic              clk108_w,
    input  logic              ram_enabled_w,
    cart_bus_if.decoder       bus,
    output sdc_pkg::mapper_t  mapper_type,
    output logic              scc_enable
);
    import sdc_pkg::*;

    logic wr_armed;
    logic cfg_wr;

    // i/o write to port 8fh decoded on the low address byte
    assign cfg_wr = bus.snap_valid && !bus.iorq_n && bus.m1_n && bus.rd_n && !bus.wr_n
                 && bus.addr[7:0] == MAPPER_CFG_PORT && wr_armed;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_type <= MAP_KONAMI_SCC;
            scc_enable  <= 1'b1;
            wr_armed    <= 1'b1;
        end else begin
            if (bus.wr_n) begin
                wr_armed <= 1'b1;
            end else if (cfg_wr) begin
                wr_armed <= 1'b0;
            end

            if (cfg_wr) begin
                scc_enable <= 1'b0;     // only konami scc keeps it
                case (bus.cdin)
                    CFG_KONAMI_SCC: begin
                        mapper_type <= MAP_KONAMI_SCC;
                        scc_enable  <= 1'b1;
                    end
                    CFG_ASCII16: mapper_type <= MAP_ASCII16;
                    CFG_ASCII8:  mapper_type <= MAP_ASCII8;
                    default:     mapper_type <= MAP_KONAMI;
                endcase
            end
        end
    end

endmodule

// ==== hw/sdc_registers.sv ====
module sdc_registers (
    input  logic                 clk108_w,
    input  logic                 ram_enabled_w,
    cart_bus_if.decoder          bus,
    output logic                 sd_req_valid,
    output logic                 sd_req_write,
    output sdc_pkg::sector_t     sd_sector,
    input  logic                 sd_req_ready,
    input  logic                 sd_done,
    input  sdc_pkg::card_type_t  sd_card_type,
    input  logic                 sd_crc_error,
    input  logic                 sd_timeout_error,
    output msx_bus_pkg::data_t   rd_data,
    output logic                 datadir
);
    import msx_bus_pkg::*;
    import sdc_pkg::*;

    logic  sd_en;
    logic  busy;
    logic  wr_armed;     // rearmed once wr_n returns high
    logic  mem_acc;
    logic  sel;
    logic  wr_hit;
    logic  rd_hit;
    logic  cmd_start;
    data_t status;
    data_t rd_mux;

    assign mem_acc = !bus.merq_n && bus.iorq_n && bus.m1_n && !bus.sltsl_n;

    // enable register answers even with the window closed
    assign sel = mem_acc && bus.addr >= SDC_ENABLE && bus.addr <= SDC_END
              && (sd_en || bus.addr == SDC_ENABLE);

    assign wr_hit = sel && bus.snap_valid && !bus.wr_n && wr_armed;
    assign rd_hit = sel && !bus.rd_n;

    assign cmd_start = wr_hit && bus.addr == SDC_CMD && !busy
                    && (bus.cdin[CMD_READ_BIT] || bus.cdin[CMD_WRITE_BIT]);

    always_comb begin
        status                   = '0;
        status[STAT_BUSY_BIT]    = busy;
        status[STAT_TIMEOUT_BIT] = sd_timeout_error;
        status[STAT_CRC_BIT]     = sd_crc_error;
    end

    always_comb begin
        case (bus.addr)
            SDC_ENABLE:         rd_mux = {7'b0, sd_en};
            SDC_STATUS:         rd_mux = status;
            SDC_SADDR:          rd_mux = sd_sector[7:0];
            SDC_SADDR + 16'd1:  rd_mux = sd_sector[15:8];
            SDC_SADDR + 16'd2:  rd_mux = sd_sector[23:16];
            SDC_SADDR + 16'd3:  rd_mux = sd_sector[31:24];
            SDC_CTYPE:          rd_mux = {6'b0, sd_card_type};
            default:            rd_mux = 8'hFF;   // unused window bytes
        endcase
    end

    ////////////////////////////////////////////////////////////
    // sector number held steady while a request is open
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk108_w) begin
        if (wr_hit && !busy) begin
            case (bus.addr)
                SDC_SADDR:         sd_sector[7:0]   <= bus.cdin;
                SDC_SADDR + 16'd1: sd_sector[15:8]  <= bus.cdin;
                SDC_SADDR + 16'd2: sd_sector[23:16] <= bus.cdin;
                SDC_SADDR + 16'd3: sd_sector[31:24] <= bus.cdin;
                default: ;
            endcase
        end
        if (rd_hit) rd_data <= rd_mux;
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_en        <= 1'b0;
            busy         <= 1'b0;
            wr_armed     <= 1'b1;
            sd_req_valid <= 1'b0;
            sd_req_write <= 1'b0;
            datadir      <= 1'b1;   // cd released
        end else begin
            if (bus.wr_n) begin
                wr_armed <= 1'b1;
            end else if (wr_hit) begin
                wr_armed <= 1'b0;   // one write per strobe
            end

            if (wr_hit && bus.addr == SDC_ENABLE) sd_en <= bus.cdin[0];

            if (sd_req_valid && sd_req_ready) sd_req_valid <= 1'b0;
            if (sd_done) busy <= 1'b0;

            // commands while busy fall through here
            if (cmd_start) begin
                busy         <= 1'b1;
                sd_req_valid <= 1'b1;
                sd_req_write <= bus.cdin[CMD_WRITE_BIT];
            end

            datadir <= !rd_hit;
        end
    end

endmodule

// ==== hw/mux_bus_sampler.sv ====
module mux_bus_sampler (
    input  logic                clk108_w,
    input  logic                ram_enabled_w,
    input  msx_bus_pkg::data_t  mp,
    input  logic                rd_n,
    input  logic                wr_n,
    input  logic                sltsl_n,
    input  msx_bus_pkg::data_t  cd_in,
    output msx_bus_pkg::msel_t  msel_n,
    cart_bus_if.sampler         bus
);
    import msx_bus_pkg::*;

    dot_state_t state;
    dot_state_t next_state;
    logic       cap_en;
    logic       ctrl_cap;
    data_t      stage_lo;
    data_t      stage_hi;

    logic [DATA_W+2:0] pins_meta;   // {rd_n, wr_n, sltsl_n, cd}
    logic [DATA_W+2:0] pins_sync;

    ////////////////////////////////////////////////////////////
    // dot sequencer
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = DOT_IDLE;
        msel_n     = MSEL_NONE;
        case (state)
            DOT_LO_SEL: begin
                next_state = DOT_LO_CAP;
                msel_n     = MSEL_ADDR_LO;
            end
            DOT_LO_CAP: begin
                next_state = DOT_HI_SEL;
                msel_n     = MSEL_ADDR_LO;
            end
            DOT_HI_SEL: begin
                next_state = DOT_HI_CAP;
                msel_n     = MSEL_ADDR_HI;
            end
            DOT_HI_CAP: begin
                next_state = DOT_CTRL_SEL;
                msel_n     = MSEL_ADDR_HI;
            end
            DOT_CTRL_SEL: begin
                next_state = DOT_CTRL_CAP;
                msel_n     = MSEL_CTRL;
            end
            DOT_CTRL_CAP: begin
                next_state = DOT_IDLE;
                msel_n     = MSEL_CTRL;
            end
            default:      next_state = DOT_LO_SEL;  // idle with nothing selected
        endcase
    end

    // mp has settled by the second cycle of a group
    assign cap_en   = (state == DOT_LO_CAP) || (state == DOT_HI_CAP) || (state == DOT_CTRL_CAP);
    assign ctrl_cap = cap_en && (msel_n == MSEL_CTRL);

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            state <= DOT_IDLE;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////
    // capture and publish
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk108_w) begin
        if (cap_en && msel_n == MSEL_ADDR_LO) stage_lo <= mp;
        if (cap_en && msel_n == MSEL_ADDR_HI) stage_hi <= mp;
        if (ctrl_cap) bus.addr <= {stage_hi, stage_lo};  // whole address at once
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            bus.snap_valid <= 1'b0;
            bus.merq_n     <= 1'b1;
            bus.iorq_n     <= 1'b1;
            bus.m1_n       <= 1'b1;
        end else begin
            bus.snap_valid <= ctrl_cap;
            if (ctrl_cap) begin
                bus.merq_n <= mp[MP_MERQ];
                bus.iorq_n <= mp[MP_IORQ];
                bus.m1_n   <= mp[MP_M1];
            end
        end
    end

    // two-flop synchronizers idle high
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            pins_meta <= '1;
            pins_sync <= '1;
        end else begin
            pins_meta <= {rd_n, wr_n, sltsl_n, cd_in};
            pins_sync <= pins_meta;
        end
    end

    assign bus.rd_n    = pins_sync[DATA_W+2];
    assign bus.wr_n    = pins_sync[DATA_W+1];
    assign bus.sltsl_n = pins_sync[DATA_W];
    assign bus.cdin    = pins_sync[DATA_W-1:0];

endmodule

// ==== hw/cart_bus_if.sv ====
interface cart_bus_if;
    import msx_bus_pkg::*;

    addr_t addr;        // published snapshot
    logic  merq_n;
    logic  iorq_n;
    logic  m1_n;
    logic  rd_n;        // synchronized strobes
    logic  wr_n;
    logic  sltsl_n;
    data_t cdin;        // synchronized cd pins
    logic  snap_valid;  // one cycle after control capture

    modport sampler (
        output addr, merq_n, iorq_n, m1_n,
        output rd_n, wr_n, sltsl_n, cdin, snap_valid
    );

    modport decoder (
        input addr, merq_n, iorq_n, m1_n,
        input rd_n, wr_n, sltsl_n, cdin, snap_valid
    );

endinterface

// ==== hw/sdc_pkg.sv ====
package sdc_pkg;

    ////////////////////////////////////////////////////////////
    // sd controller register window
    ////////////////////////////////////////////////////////////

    localparam msx_bus_pkg::addr_t SDC_ENABLE = 16'h7E00; // bit 0 opens the window
    localparam msx_bus_pkg::addr_t SDC_CMD    = 16'h7E01; // 1 starts a read and 2 a write
    localparam msx_bus_pkg::addr_t SDC_STATUS = 16'h7E02; // read only
    localparam msx_bus_pkg::addr_t SDC_SADDR  = 16'h7E03; // four bytes with the lsb first
    localparam msx_bus_pkg::addr_t SDC_CTYPE  = 16'h7E0E; // read only
    localparam msx_bus_pkg::addr_t SDC_END    = 16'h7EFF;

    // command byte
    localparam int CMD_READ_BIT  = 0;
    localparam int CMD_WRITE_BIT = 1;

    // status byte
    localparam int STAT_BUSY_BIT    = 7;
    localparam int STAT_TIMEOUT_BIT = 1;
    localparam int STAT_CRC_BIT     = 0;

    typedef logic [31:0] sector_t;

    // 0 unknown, 1 sdv1, 2 sdv2, 3 sdhcv2
    typedef logic [1:0] card_type_t;

    ////////////////////////////////////////////////////////////
    // megaram mapper configuration
    ////////////////////////////////////////////////////////////

    localparam msx_bus_pkg::data_t MAPPER_CFG_PORT = 8'h8F;

    typedef enum logic [1:0] {
        MAP_KONAMI     = 2'd0,
        MAP_KONAMI_SCC = 2'd1,
        MAP_ASCII16    = 2'd2,
        MAP_ASCII8     = 2'd3
    } mapper_t;

    localparam msx_bus_pkg::data_t CFG_KONAMI_SCC = 8'h05;
    localparam msx_bus_pkg::data_t CFG_ASCII16    = 8'h16;
    localparam msx_bus_pkg::data_t CFG_ASCII8     = 8'h08;

endpackage

// ==== hw/msx_bus_pkg.sv ====
package msx_bus_pkg;

    ////////////////////////////////////////////////////////////
    // cartridge bus widths and types
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W = 16;     // z80 address
    localparam int DATA_W = 8;      // cd / mp pins

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // active low select groups on msel_n
    typedef enum logic [2:0] {
        MSEL_ADDR_LO = 3'b110,      // a0-a7
        MSEL_ADDR_HI = 3'b101,      // a8-a15
        MSEL_CTRL    = 3'b011,      // merq, iorq, cs1, cs2, res, rfsh, cs12, m1
        MSEL_NONE    = 3'b111
    } msel_t;

    // seven dot steps make one sampler period
    typedef enum logic [2:0] {
        DOT_LO_SEL,
        DOT_LO_CAP,
        DOT_HI_SEL,
        DOT_HI_CAP,
        DOT_CTRL_SEL,
        DOT_CTRL_CAP,
        DOT_IDLE
    } dot_state_t;

    // bit positions inside the control group
    localparam int MP_MERQ = 0;
    localparam int MP_IORQ = 1;
    localparam int MP_M1   = 7;

endpackage
